/* Bender.yml */
package:
  name: tcm

sources:
  - tcm_pkg.sv
  - bank_if.sv
  - tcm_bank.sv
  - tcm_split.sv
  - tcm_merge.sv
  - tcm_top.sv
  - target: test
    files:
      - tb_tcm.sv

/* bank_if.sv */
`timescale 1ns/1ps

// One RAM bank port: index, strobes, write data, registered read data
interface bank_if #(
   parameter int BANK_AW = 6
);

   logic [BANK_AW-1:0] idx;   // Word index inside the bank
   logic               re;    // Read strobe
   tcm_pkg::bmask_t    we;    // Byte write lanes
   tcm_pkg::word_t     din;   // Write data, already rotated
   tcm_pkg::word_t     dout;  // Registered read word

   // Splitter side
   modport split (output idx, output re, output we, output din);

   // RAM side
   modport bank (input idx, input re, input we, input din, output dout);

   // Merge side only needs the read word
   modport merge (input dout);

endinterface

/* project.f */
tcm_pkg.sv
bank_if.sv
tcm_bank.sv
tcm_split.sv
tcm_merge.sv
tcm_top.sv
tb_tcm.sv

/* tb_tcm.sv */
`timescale 1ns/1ps

module tb_tcm;

   localparam int AW         = 4;              // Bank index width for this run
   localparam int ADDR_W     = AW + 3;         // Byte address width
   localparam int MEM_BYTES  = 1 << ADDR_W;    // Both banks together
   localparam int NWORDS     = MEM_BYTES / 4;
   localparam int MAX_CYCLES = 2000;           // Tests need about 700

   logic                CLK;
   logic                rst_n;
   logic                req_rd;
   logic                req_wr;
   logic [ADDR_W-1:0]   addr;
   tcm_pkg::size_t      size;
   tcm_pkg::word_t      wdata;
   tcm_pkg::word_t      rdata;
   logic                rvalid;

   logic [7:0]          model [0:MEM_BYTES-1];  // Byte-wide reference memory
   tcm_pkg::word_t      load_exp;               // Expected result of the load being driven
   tcm_pkg::word_t      exp_data_q;             // Carried one cycle, lines up with rdata
   logic                exp_valid_q;
   logic                data_seen;              // Set once a first load went out
   integer              seed;
   int                  err_count   = 0;
   int                  tests_pass  = 0;
   int                  tests_fail  = 0;
   int                  cycle_count = 0;

   tcm_top #(
      .BANK_AW (AW)
   ) tcm_top_inst (
      .CLK    (CLK),
      .rst_n  (rst_n),
      .req_rd (req_rd),
      .req_wr (req_wr),
      .addr   (addr),
      .size   (size),
      .wdata  (wdata),
      .rdata  (rdata),
      .rvalid (rvalid)
   );

   initial CLK = 1'b0;
   always #5 CLK = ~CLK;  // 10 ns period

   // Expectation follows the load strobe by one edge
   always @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         exp_valid_q <= 1'b0;
         data_seen   <= 1'b0;
      end
      else
      begin
         exp_valid_q <= req_rd;
         if (req_rd)
         begin
            exp_data_q <= load_exp;
            data_seen  <= 1'b1;
         end
      end
   end

   // Outputs are settled by the falling edge
   a_rvalid_ok: assert property (@(negedge CLK) disable iff (!rst_n)
      rvalid === exp_valid_q)
      else
      begin
         err_count++;
         $display("FAILED at %0t: rvalid expected %0b, got %0b", $time, exp_valid_q, rvalid);
      end

   // Also covers rdata holding between loads
   a_rdata_ok: assert property (@(negedge CLK) disable iff (!rst_n)
      data_seen |-> rdata === exp_data_q)
      else
      begin
         err_count++;
         $display("FAILED at %0t: rdata expected %h, got %h", $time, exp_data_q, rdata);
      end

   always @(posedge CLK)
   begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES)
      begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Errors found");
         $finish;
      end
   end

   // Bytes covered by each access size
   function automatic int size_len(input tcm_pkg::size_t s);
      case (s)
         tcm_pkg::size_byte: return 1;
         tcm_pkg::size_half: return 2;
         default:            return 4;
      endcase
   endfunction

   task automatic store_access(input logic [ADDR_W-1:0] a, input tcm_pkg::size_t s,
                               input tcm_pkg::word_t d);
      int n;
      n = size_len(s);
      @(negedge CLK);
      req_wr = 1'b1;
      req_rd = 1'b0;
      addr   = a;
      size   = s;
      wdata  = d;  // Upper bytes left as they are, the mask drops them
      for (int i = 0; i < n; i++)
         model[(int'(a) + i) % MEM_BYTES] = d[8*i +: 8];  // Wraps past the top
   endtask

   task automatic load_access(input logic [ADDR_W-1:0] a, input tcm_pkg::size_t s);
      int n;
      n = size_len(s);
      @(negedge CLK);
      req_rd   = 1'b1;
      req_wr   = 1'b0;
      addr     = a;
      size     = s;
      load_exp = '0;  // Zero extension
      for (int i = 0; i < n; i++)
         load_exp[8*i +: 8] = model[(int'(a) + i) % MEM_BYTES];
   endtask

   task automatic idle(input int cycles);
      repeat (cycles)
      begin
         @(negedge CLK);
         req_rd = 1'b0;
         req_wr = 1'b0;
      end
   endtask

   // Drains the last check, then reports
   task automatic end_test(input string name, input int mark);
      idle(3);
      if (err_count == mark)
      begin
         tests_pass++;
         $display("%s: passed", name);
      end
      else
      begin
         tests_fail++;
         $display("%s: failed with %0d mismatches", name, err_count - mark);
      end
   endtask

   initial
   begin
      int                mark;
      logic [ADDR_W-1:0] a;
      tcm_pkg::size_t    s;
      tcm_pkg::word_t    d;
      seed     = 38;
      rst_n    = 1'b0;
      req_rd   = 1'b0;
      req_wr   = 1'b0;
      addr     = '0;
      size     = tcm_pkg::size_byte;
      wdata    = '0;
      load_exp = '0;
      repeat (5) @(posedge CLK);
      @(negedge CLK);
      rst_n = 1'b1;

      // Quiet after reset, then one pulse per load back to back
      mark = err_count;
      idle(4);
      for (int i = 0; i < 6; i++)
         load_access($random(seed), tcm_pkg::size_word);  // RAM still unwritten
      end_test("reset_and_rvalid", mark);

      mark = err_count;
      for (int w = 0; w < NWORDS; w++)
         store_access(w * 4, tcm_pkg::size_word, $random(seed));
      for (int w = 0; w < NWORDS; w++)
         load_access(w * 4, tcm_pkg::size_word);
      end_test("aligned_words", mark);

      mark = err_count;
      for (int i = 0; i < 40; i++)
      begin
         a = $random(seed);
         s = tcm_pkg::size_t'({$random(seed)} % 2);  // Byte or halfword
         store_access(a, s, $random(seed));
         load_access(a, tcm_pkg::size_t'({$random(seed)} % 2));
         load_access({a[ADDR_W-1:2], 2'b00}, tcm_pkg::size_word);  // Neighbours intact
      end
      end_test("narrow_merge", mark);

      // Odd w straddles odd to even, even w the other way
      mark = err_count;
      for (int w = 0; w < NWORDS - 1; w++)
      begin
         a = w * 4 + 1 + (w % 3);
         store_access(a, tcm_pkg::size_word, $random(seed));
         load_access(a, tcm_pkg::size_word);
         store_access(w * 4 + 3, tcm_pkg::size_half, $random(seed));
         load_access(w * 4 + 3, tcm_pkg::size_half);
      end
      end_test("straddle", mark);

      mark = err_count;
      for (int o = 1; o < 4; o++)
      begin
         a = MEM_BYTES - 4 + o;
         store_access(a, tcm_pkg::size_word, $random(seed));
         load_access(a, tcm_pkg::size_word);
         load_access('0, tcm_pkg::size_word);  // Wrapped bytes at the bottom
      end
      end_test("wrap", mark);

      // Load right behind the store, then a random mix
      mark = err_count;
      for (int i = 0; i < 16; i++)
      begin
         a = $random(seed);
         s = tcm_pkg::size_t'({$random(seed)} % 3);
         store_access(a, s, $random(seed));
         load_access(a, s);
      end
      for (int i = 0; i < 300; i++)
      begin
         a = $random(seed);
         s = tcm_pkg::size_t'({$random(seed)} % 3);
         d = $random(seed);
         if ({$random(seed)} % 2)
            store_access(a, s, d);
         else
            load_access(a, s);
      end
      end_test("store_load_mix", mark);

      $display("Tests: %0d passed, %0d failed, %0d mismatches",
               tests_pass, tests_fail, err_count);
      if (err_count == 0 && tests_fail == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

/* tcm_bank.sv */
`timescale 1ns/1ps

module tcm_bank #(
   parameter int BANK_AW = 6
) (
   input  logic CLK,
   input  logic rst_n,
   bank_if.bank port
);

   localparam int DEPTH = 1 << BANK_AW;  // Words per bank

   tcm_pkg::word_t mem [0:DEPTH-1];      // Storage, no reset

   // Registered read, held while re is low
   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         port.dout <= '0;
      end
      else if (port.re)
      begin
         port.dout <= mem[port.idx];
      end
   end

   // Byte lanes written independently
   always_ff @(posedge CLK)
   begin
      for (int b = 0; b < tcm_pkg::WORD_BYTES; b++)
      begin
         if (port.we[b])
         begin
            mem[port.idx][b*8 +: 8] <= port.din[b*8 +: 8];
         end
      end
   end

   // Splitter must hand over a clean index on every access
   a_idx_known: assert property (@(posedge CLK) disable iff (!rst_n)
      (port.re || (|port.we)) |-> !$isunknown(port.idx))
      else $error("tcm_bank: unknown index on access");

endmodule

/* tcm_merge.sv */
`timescale 1ns/1ps

module tcm_merge #(
   parameter int BANK_AW = 6
) (
   input  logic               CLK,
   input  logic               rst_n,
   input  logic [BANK_AW+2:0] addr,
   input  tcm_pkg::size_t     size,
   input  logic               req_rd,
   bank_if.merge              even,
   bank_if.merge              odd,
   output tcm_pkg::word_t     rdata,
   output logic               rvalid
);

   localparam int WIN_W = tcm_pkg::WIN_BYTES * 8;

   tcm_pkg::rot_t    rot_q;        // Offset of the load in its first word
   logic             first_odd_q;  // First word came from the odd bank
   tcm_pkg::size_t   size_q;
   logic [WIN_W-1:0] win;          // First word low, second word high
   logic [WIN_W-1:0] win_rot;
   tcm_pkg::bmask_t  keep;         // Bytes the size lets through

   // Shape of the load, captured with the bank read
   always_ff @(posedge CLK or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rvalid      <= 1'b0;
         rot_q       <= '0;
         first_odd_q <= 1'b0;
         size_q      <= tcm_pkg::size_byte;
      end
      else
      begin
         rvalid <= req_rd;  // One pulse per load
         if (req_rd)
         begin
            rot_q       <= {1'b0, addr[1:0]};
            first_odd_q <= addr[2];  // Low bit of the word address
            size_q      <= size;
         end
      end
   end

   // Put the words in access order, then bring the addressed byte to lane 0
   assign win     = first_odd_q ? {even.dout, odd.dout} : {odd.dout, even.dout};
   assign win_rot = win >> {rot_q, 3'b000};
   assign keep    = tcm_pkg::size_bmask(size_q);

   // Zero extension of narrow loads
   always_comb
   begin
      for (int b = 0; b < tcm_pkg::WORD_BYTES; b++)
      begin
         rdata[b*8 +: 8] = keep[b] ? win_rot[b*8 +: 8] : 8'h00;
      end
   end

   // Offset, bank order and size latched on a load must be clean
   a_shape_known: assert property (@(posedge CLK) disable iff (!rst_n)
      req_rd |-> !$isunknown({addr[2:0], size}))
      else $error("tcm_merge: unknown offset or size on load");

endmodule

/* tcm_pkg.sv */
package tcm_pkg;

   typedef logic [31:0] word_t;   // One bank word or core data value
   typedef logic [3:0]  bmask_t;  // Byte lanes of one bank word
   typedef logic [2:0]  rot_t;    // Byte offset in the two-word window

   // Access size of a core load or store
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } size_t;

   localparam int WORD_BYTES = 4;               // Bytes per bank word
   localparam int WIN_BYTES  = 2 * WORD_BYTES;  // Even plus odd word

   // Low-aligned lanes touched by an access of the given size
   function automatic bmask_t size_bmask(input size_t sz);
      bmask_t m;
      case (sz)
         size_byte: m = 4'b0001;
         size_half: m = 4'b0011;
         size_word: m = 4'b1111;
         default:   m = 4'b0000;  // Illegal code touches nothing
      endcase
      return m;
   endfunction

endpackage

/* tcm_split.sv */
`timescale 1ns/1ps

module tcm_split #(
   parameter int BANK_AW = 6
) (
   input  logic [BANK_AW+2:0] addr,
   input  tcm_pkg::size_t     size,
   input  tcm_pkg::word_t     wdata,
   input  logic               req_rd,
   input  logic               req_wr,
   bank_if.split              even,
   bank_if.split              odd
);

   localparam int WIN_W = tcm_pkg::WIN_BYTES * 8;  // Two words side by side

   typedef logic [BANK_AW:0] waddr_t;  // Word address over both banks

   waddr_t                        w_first;    // Word holding addr
   waddr_t                        w_second;   // Next word, wraps at the top
   logic                          first_odd;  // First word sits in odd bank
   tcm_pkg::rot_t                 ofs;        // Byte offset in first word
   logic [tcm_pkg::WIN_BYTES-1:0] win_mask;   // Covered bytes of the window
   logic [WIN_W-1:0]              win_data;   // Store data moved to its bytes
   tcm_pkg::bmask_t               lo_mask;
   tcm_pkg::bmask_t               hi_mask;

   assign w_first   = addr[BANK_AW+2:2];
   assign w_second  = w_first + 1'b1;  // Rolls over to word zero
   assign first_odd = w_first[0];
   assign ofs       = {1'b0, addr[1:0]};

   // Size mask and data shifted up by the offset
   assign win_mask = {{tcm_pkg::WORD_BYTES{1'b0}}, tcm_pkg::size_bmask(size)} << ofs;
   assign win_data = {{(WIN_W-32){1'b0}}, wdata} << {ofs, 3'b000};

   // Lanes only on a store
   assign lo_mask = req_wr ? win_mask[3:0] : '0;
   assign hi_mask = req_wr ? win_mask[7:4] : '0;

   // Low half of the window belongs to whichever bank holds the first word
   assign even.idx = first_odd ? w_second[BANK_AW:1] : w_first[BANK_AW:1];
   assign odd.idx  = first_odd ? w_first[BANK_AW:1]  : w_second[BANK_AW:1];

   assign even.we  = first_odd ? hi_mask : lo_mask;
   assign odd.we   = first_odd ? lo_mask : hi_mask;

   assign even.din = first_odd ? win_data[63:32] : win_data[31:0];
   assign odd.din  = first_odd ? win_data[31:0]  : win_data[63:32];

   // Both banks read on every load, merge picks the order
   assign even.re  = req_rd;
   assign odd.re   = req_rd;

   // Core side rules, checked once inputs settle
   always_comb
   begin
      a_rd_wr_excl: assert #0 (!(req_rd === 1'b1 && req_wr === 1'b1))
         else $error("tcm_split: load and store strobed together");
      a_size_legal: assert #0 (!(req_rd === 1'b1 || req_wr === 1'b1) ||
                               size inside {tcm_pkg::size_byte, tcm_pkg::size_half,
                                            tcm_pkg::size_word})
         else $error("tcm_split: illegal access size %0d", size);
   end

endmodule

/* tcm_top.sv */
`timescale 1ns/1ps

module tcm_top #(
   parameter int BANK_AW = 6  // Bank index width, at least 2
) (
   input  logic               CLK,
   input  logic               rst_n,
   input  logic               req_rd,  // Load strobe
   input  logic               req_wr,  // Store strobe
   input  logic [BANK_AW+2:0] addr,    // Byte address
   input  tcm_pkg::size_t     size,
   input  tcm_pkg::word_t     wdata,   // Store data in the low bytes
   output tcm_pkg::word_t     rdata,   // Zero-extended load result
   output logic               rvalid
);

   // Even and odd word banks
   bank_if #(.BANK_AW(BANK_AW)) bank_even ();
   bank_if #(.BANK_AW(BANK_AW)) bank_odd ();

   // Core access to per-bank strobes
   tcm_split #(
      .BANK_AW (BANK_AW)
   ) tcm_split_inst (
      .addr   (addr),
      .size   (size),
      .wdata  (wdata),
      .req_rd (req_rd),
      .req_wr (req_wr),
      .even   (bank_even.split),
      .odd    (bank_odd.split)
   );

   tcm_bank #(
      .BANK_AW (BANK_AW)
   ) bank_even_inst (
      .CLK   (CLK),
      .rst_n (rst_n),
      .port  (bank_even.bank)
   );

   tcm_bank #(
      .BANK_AW (BANK_AW)
   ) bank_odd_inst (
      .CLK   (CLK),
      .rst_n (rst_n),
      .port  (bank_odd.bank)
   );

   // Bank words back to one load result
   tcm_merge #(
      .BANK_AW (BANK_AW)
   ) tcm_merge_inst (
      .CLK    (CLK),
      .rst_n  (rst_n),
      .addr   (addr),
      .size   (size),
      .req_rd (req_rd),
      .even   (bank_even.merge),
      .odd    (bank_odd.merge),
      .rdata  (rdata),
      .rvalid (rvalid)
   );

endmodule
